//--- mcr_input_defs.svh
//====================================================================
// Widths, register bit positions and reset values for the MCR-II
// input front end. Include wherever a width or bit index is needed
//====================================================================
`ifndef MCR_INPUT_DEFS_SVH
`define MCR_INPUT_DEFS_SVH

`define MCR_PORT_W      8
`define MCR_BTN_W       6
`define MCR_SYS_W       5
`define MCR_MOUSE_W     9
`define MCR_WACKO_W     11
`define MCR_KROOZR_W    10
`define MCR_ANGLE_W     7
`define MCR_APB_AW      4
`define MCR_CTRL_W      5

// Player button vector
`define BTN_RIGHT       0
`define BTN_LEFT        1
`define BTN_DOWN        2
`define BTN_UP          3
`define BTN_FIRE_A      4
`define BTN_FIRE_B      5

// System button vector
`define SYS_COIN1       0
`define SYS_COIN2       1
`define SYS_START1      2
`define SYS_START2      3
`define SYS_TILT        4

// Control register
`define CTRL_ROTATE     0
`define CTRL_SERVICE    1
`define CTRL_SPIN_FAST  2
`define CTRL_SKIN       3
`define CTRL_MUSIC      4

`define MCR_CTRL_RST    5'b00000
`define MCR_PORT_IDLE   8'hFF  // Nothing pressed
`define MCR_SPIN_STEP      1
`define MCR_SPIN_STEP_FAST 2

`endif

//--- mcr_input_pkg.sv
//====================================================================
// Shared types for the MCR-II input front end
// Game codes keep the board's original mode numbers
//====================================================================
`include "mcr_input_defs.svh"

package mcr_input_pkg;

	typedef enum logic [2:0] {
		GAME_SHOLLOW = 3'd0,
		GAME_WACKO   = 3'd3,
		GAME_KROOZR  = 3'd4,
		GAME_DOMINO  = 3'd5
	} game_e;

	// APB register offsets
	typedef enum logic [`MCR_APB_AW-1:0] {
		REG_GAME = `MCR_APB_AW'(4'h0),
		REG_CTRL = `MCR_APB_AW'(4'h4)
	} reg_addr_e;

	// True for the codes of the four supported games
	function automatic logic game_legal(input logic [2:0] code);
		logic ok;
		case (code)
			GAME_SHOLLOW, GAME_WACKO, GAME_KROOZR, GAME_DOMINO: ok = 1'b1;
			default: ok = 1'b0;
		endcase
		return ok;
	endfunction

endpackage

//--- mcr_cfg_regs.sv
//====================================================================
// APB slave holding the game select and control registers
// Zero wait states, no error response. Unmapped offsets read as 0
//====================================================================
`include "mcr_input_defs.svh"

module mcr_cfg_regs (
	input  logic                    clk_sys,
	input  logic                    rst_n_i,
	input  logic                    psel_i,
	input  logic                    penable_i,
	input  logic                    pwrite_i,
	input  logic [`MCR_APB_AW-1:0]  paddr_i,
	input  logic [31:0]             pwdata_i,
	output logic [31:0]             prdata_o,
	output logic                    pready_o,
	output mcr_input_pkg::game_e    game_o,
	output logic [`MCR_CTRL_W-1:0]  ctrl_o
);

	import mcr_input_pkg::*;

	game_e                   game_q;
	logic [`MCR_CTRL_W-1:0]  ctrl_q;
	logic                    wr_en;
	logic                    rd_en;

	assign pready_o = 1'b1;  // Every access completes at once

	assign wr_en = psel_i & penable_i & pwrite_i;
	assign rd_en = psel_i & ~pwrite_i;

	//==================================================================
	// Register writes
	//==================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			game_q <= GAME_SHOLLOW;
			ctrl_q <= `MCR_CTRL_RST;
		end else if (wr_en) begin
			case (paddr_i)
				REG_GAME: begin
					// Unknown codes leave the current game running
					if (game_legal(pwdata_i[2:0])) begin
						game_q <= game_e'(pwdata_i[2:0]);
					end
				end
				REG_CTRL: ctrl_q <= pwdata_i[`MCR_CTRL_W-1:0];
				default: ;
			endcase
		end
	end

	//==================================================================
	// Read-back
	//==================================================================
	always_comb begin
		prdata_o = 32'd0;
		if (rd_en) begin
			case (paddr_i)
				REG_GAME: prdata_o = {29'd0, game_q};
				REG_CTRL: prdata_o = {{(32-`MCR_CTRL_W){1'b0}}, ctrl_q};
				default:  prdata_o = 32'd0;
			endcase
		end
	end

	assign game_o = game_q;
	assign ctrl_o = ctrl_q;

	// Access phase always has the slave selected
	a_penable_sel: assert property (
		@(posedge clk_sys) disable iff (!rst_n_i)
		penable_i |-> psel_i
	);

	// Setup phase is always followed by the access phase
	a_setup_access: assert property (
		@(posedge clk_sys) disable iff (!rst_n_i)
		(psel_i && !penable_i) |=> (psel_i && penable_i)
	);

endmodule

//--- mcr_mouse_track.sv
//====================================================================
// Mouse position tracking for Wacko and Kozmik Krooz'r
// Wacko wraps at 11 bits, Krooz'r saturates at 10 bits per axis.
// Mouse buttons are latched on every strobe
//====================================================================
`include "mcr_input_defs.svh"

module mcr_mouse_track (
	input  logic                            clk_sys,
	input  logic                            rst_n_i,
	input  logic                            mouse_strobe_i,
	input  logic signed [`MCR_MOUSE_W-1:0]  mouse_x_i,
	input  logic signed [`MCR_MOUSE_W-1:0]  mouse_y_i,
	input  logic [1:0]                      mouse_btn_i,
	input  logic                            rotate_i,
	output logic signed [`MCR_WACKO_W-1:0]  wacko_x_o,
	output logic signed [`MCR_WACKO_W-1:0]  wacko_y_o,
	output logic signed [`MCR_KROOZR_W-1:0] kroozr_x_o,
	output logic signed [`MCR_KROOZR_W-1:0] kroozr_y_o,
	output logic [1:0]                      mouse_btn_o
);

	logic signed [`MCR_WACKO_W-1:0]  mx_w;
	logic signed [`MCR_WACKO_W-1:0]  my_w;
	logic signed [`MCR_MOUSE_W-1:0]  move_x;
	logic signed [`MCR_MOUSE_W-1:0]  move_y;
	logic signed [`MCR_KROOZR_W-1:0] move_x_k;
	logic signed [`MCR_KROOZR_W-1:0] move_y_k;
	logic signed [`MCR_KROOZR_W-1:0] kx_new;
	logic signed [`MCR_KROOZR_W-1:0] ky_new;
	logic                            kx_ovf;
	logic                            ky_ovf;

	// Sign extended deltas for the Wacko accumulators
	assign mx_w = {{(`MCR_WACKO_W-`MCR_MOUSE_W){mouse_x_i[`MCR_MOUSE_W-1]}}, mouse_x_i};
	assign my_w = {{(`MCR_WACKO_W-`MCR_MOUSE_W){mouse_y_i[`MCR_MOUSE_W-1]}}, mouse_y_i};

	//==================================================================
	// Krooz'r step with overflow check
	//==================================================================
	assign move_x = rotate_i ? -mouse_y_i : mouse_x_i;
	assign move_y = rotate_i ?  mouse_x_i : mouse_y_i;

	assign move_x_k = {{(`MCR_KROOZR_W-`MCR_MOUSE_W){move_x[`MCR_MOUSE_W-1]}}, move_x};
	assign move_y_k = {{(`MCR_KROOZR_W-`MCR_MOUSE_W){move_y[`MCR_MOUSE_W-1]}}, move_y};

	assign kx_new = kroozr_x_o - move_x_k;  // X runs opposite to the mouse
	assign ky_new = kroozr_y_o + move_y_k;

	// Sign flip that the operands cannot produce
	assign kx_ovf = (move_x_k[`MCR_KROOZR_W-1] != kroozr_x_o[`MCR_KROOZR_W-1]) &&
	                (kx_new[`MCR_KROOZR_W-1] != kroozr_x_o[`MCR_KROOZR_W-1]);
	assign ky_ovf = (move_y_k[`MCR_KROOZR_W-1] == kroozr_y_o[`MCR_KROOZR_W-1]) &&
	                (ky_new[`MCR_KROOZR_W-1] != kroozr_y_o[`MCR_KROOZR_W-1]);

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			wacko_x_o   <= '0;
			wacko_y_o   <= '0;
			kroozr_x_o  <= '0;
			kroozr_y_o  <= '0;
			mouse_btn_o <= 2'b00;
		end else if (mouse_strobe_i) begin
			mouse_btn_o <= mouse_btn_i;
			if (rotate_i) begin
				wacko_x_o <= wacko_x_o - my_w;
				wacko_y_o <= wacko_y_o + mx_w;
			end else begin
				wacko_x_o <= wacko_x_o + mx_w;
				wacko_y_o <= wacko_y_o + my_w;
			end
			if (!kx_ovf) kroozr_x_o <= kx_new;  // Hold at the edge
			if (!ky_ovf) kroozr_y_o <= ky_new;
		end
	end

	a_known: assert property (
		@(posedge clk_sys) disable iff (!rst_n_i)
		!$isunknown({wacko_x_o, wacko_y_o, kroozr_x_o, kroozr_y_o, mouse_btn_o})
	);

endmodule

//--- mcr_spinner.sv
//====================================================================
// Spinner emulation from direction buttons
// The angle steps once per frame, on the rising edge of vblank
//====================================================================
`include "mcr_input_defs.svh"

module mcr_spinner (
	input  logic                    clk_sys,
	input  logic                    rst_n_i,
	input  logic                    vblank_i,
	input  logic                    spin_left_i,
	input  logic                    spin_right_i,
	input  logic                    fast_i,
	output logic [`MCR_ANGLE_W-1:0] angle_o
);

	logic                    vblank_q;
	logic                    tick_q;
	logic [`MCR_ANGLE_W-1:0] step;
	logic [`MCR_ANGLE_W-1:0] angle_q;

	assign step = fast_i ? `MCR_ANGLE_W'(`MCR_SPIN_STEP_FAST) : `MCR_ANGLE_W'(`MCR_SPIN_STEP);

	// Frame tick, registered
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			vblank_q <= 1'b0;
			tick_q   <= 1'b0;
		end else begin
			vblank_q <= vblank_i;
			tick_q   <= vblank_i & ~vblank_q;
		end
	end

	//==================================================================
	// Angle, wraps modulo 128
	//==================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			angle_q <= '0;
		end else if (tick_q) begin
			if (spin_left_i && !spin_right_i) begin
				angle_q <= angle_q - step;
			end else if (spin_right_i && !spin_left_i) begin
				angle_q <= angle_q + step;
			end
			// Both or neither held, no movement
		end
	end

	assign angle_o = angle_q;

endmodule

//--- mcr_port_map.sv
//====================================================================
// Maps buttons, mouse and spinner into the five active-low port
// bytes read by the game board. Bytes are registered
//====================================================================
`include "mcr_input_defs.svh"

module mcr_port_map (
	input  logic                            clk_sys,
	input  logic                            rst_n_i,
	input  mcr_input_pkg::game_e            game_i,
	input  logic [`MCR_CTRL_W-1:0]          ctrl_i,
	input  logic [`MCR_BTN_W-1:0]           p1_btn_i,
	input  logic [`MCR_BTN_W-1:0]           p2_btn_i,
	input  logic [`MCR_SYS_W-1:0]           sys_btn_i,
	input  logic signed [`MCR_WACKO_W-1:0]  wacko_x_i,
	input  logic signed [`MCR_WACKO_W-1:0]  wacko_y_i,
	input  logic signed [`MCR_KROOZR_W-1:0] kroozr_x_i,
	input  logic signed [`MCR_KROOZR_W-1:0] kroozr_y_i,
	input  logic [1:0]                      mouse_btn_i,
	input  logic [`MCR_ANGLE_W-1:0]         angle_i,
	output logic [`MCR_PORT_W-1:0]          input_0_o,
	output logic [`MCR_PORT_W-1:0]          input_1_o,
	output logic [`MCR_PORT_W-1:0]          input_2_o,
	output logic [`MCR_PORT_W-1:0]          input_3_o,
	output logic [`MCR_PORT_W-1:0]          input_4_o
);

	import mcr_input_pkg::*;

	logic [`MCR_PORT_W-1:0] in0_d;
	logic [`MCR_PORT_W-1:0] in1_d;
	logic [`MCR_PORT_W-1:0] in2_d;
	logic [`MCR_PORT_W-1:0] in3_d;
	logic [`MCR_PORT_W-1:0] in4_d;
	logic                   x_bit;  // Game specific bit 4 of input_0

	always_comb begin
		in1_d = `MCR_PORT_IDLE;
		in2_d = `MCR_PORT_IDLE;
		in3_d = `MCR_PORT_IDLE;
		in4_d = `MCR_PORT_IDLE;
		x_bit = 1'b0;
		case (game_i)
			GAME_SHOLLOW: begin
				in1_d = ~{p2_btn_i[`BTN_FIRE_A], p2_btn_i[`BTN_FIRE_B],
				          p2_btn_i[`BTN_RIGHT], p2_btn_i[`BTN_LEFT],
				          p1_btn_i[`BTN_FIRE_A], p1_btn_i[`BTN_FIRE_B],
				          p1_btn_i[`BTN_RIGHT], p1_btn_i[`BTN_LEFT]};
				in3_d = 8'hFD;
			end
			GAME_WACKO: begin
				in1_d = wacko_x_i[`MCR_WACKO_W-1 -: `MCR_PORT_W];  // Top 8 bits
				in2_d = wacko_y_i[`MCR_WACKO_W-1 -: `MCR_PORT_W];
				in3_d = 8'hBF;
				in4_d = ~{p2_btn_i[`BTN_UP], p2_btn_i[`BTN_DOWN],
				          p2_btn_i[`BTN_LEFT], p2_btn_i[`BTN_RIGHT],
				          p1_btn_i[`BTN_UP], p1_btn_i[`BTN_DOWN],
				          p1_btn_i[`BTN_LEFT], p1_btn_i[`BTN_RIGHT]};
			end
			GAME_KROOZR: begin
				x_bit = p1_btn_i[`BTN_FIRE_A] | mouse_btn_i[0];
				in1_d = ~{p1_btn_i[`BTN_FIRE_B] | mouse_btn_i[1],
				          angle_i[`MCR_ANGLE_W-1], 3'b111, angle_i[5:3]};
				// Sign bit doubled above the position
				in2_d = {kroozr_x_i[`MCR_KROOZR_W-1], kroozr_x_i[`MCR_KROOZR_W-1],
				         kroozr_x_i[7:2]};
				in3_d = 8'hBF;
				in4_d = {kroozr_y_i[`MCR_KROOZR_W-1], kroozr_y_i[`MCR_KROOZR_W-1],
				         kroozr_y_i[7:2]};
			end
			GAME_DOMINO: begin
				x_bit = p1_btn_i[`BTN_FIRE_A];
				in1_d = ~{4'b0000, p1_btn_i[`BTN_DOWN], p1_btn_i[`BTN_UP],
				          p1_btn_i[`BTN_RIGHT], p1_btn_i[`BTN_LEFT]};
				in2_d = ~{3'b000, p2_btn_i[`BTN_FIRE_A], p2_btn_i[`BTN_DOWN],
				          p2_btn_i[`BTN_UP], p2_btn_i[`BTN_RIGHT], p2_btn_i[`BTN_LEFT]};
				in3_d = ~{6'b010000, ctrl_i[`CTRL_SKIN], ctrl_i[`CTRL_MUSIC]};  // DIP bits
			end
			default: ;
		endcase
		// Coins, starts and service are common to all games
		in0_d = ~{ctrl_i[`CTRL_SERVICE], 1'b0, sys_btn_i[`SYS_TILT], x_bit,
		          sys_btn_i[`SYS_START2], sys_btn_i[`SYS_START1],
		          sys_btn_i[`SYS_COIN2], sys_btn_i[`SYS_COIN1]};
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			input_0_o <= `MCR_PORT_IDLE;
			input_1_o <= `MCR_PORT_IDLE;
			input_2_o <= `MCR_PORT_IDLE;
			input_3_o <= `MCR_PORT_IDLE;
			input_4_o <= `MCR_PORT_IDLE;
		end else begin
			input_0_o <= in0_d;
			input_1_o <= in1_d;
			input_2_o <= in2_d;
			input_3_o <= in3_d;
			input_4_o <= in4_d;
		end
	end

	// Register block never hands over an unsupported game
	a_game_legal: assert property (
		@(posedge clk_sys) disable iff (!rst_n_i)
		game_legal(game_i)
	);

endmodule

//--- mcr_input_top.sv
//====================================================================
// MCR-II control input front end
// APB configuration, mouse and spinner tracking, port byte mapping
//====================================================================
`include "mcr_input_defs.svh"

module mcr_input_top (
	input  logic                            clk_sys,
	input  logic                            rst_n_i,
	input  logic                            psel_i,
	input  logic                            penable_i,
	input  logic                            pwrite_i,
	input  logic [`MCR_APB_AW-1:0]          paddr_i,
	input  logic [31:0]                     pwdata_i,
	output logic [31:0]                     prdata_o,
	output logic                            pready_o,
	input  logic [`MCR_BTN_W-1:0]           p1_btn_i,
	input  logic [`MCR_BTN_W-1:0]           p2_btn_i,
	input  logic [`MCR_SYS_W-1:0]           sys_btn_i,
	input  logic                            mouse_strobe_i,
	input  logic signed [`MCR_MOUSE_W-1:0]  mouse_x_i,
	input  logic signed [`MCR_MOUSE_W-1:0]  mouse_y_i,
	input  logic [1:0]                      mouse_btn_i,
	input  logic                            vblank_i,
	output logic [`MCR_PORT_W-1:0]          input_0_o,
	output logic [`MCR_PORT_W-1:0]          input_1_o,
	output logic [`MCR_PORT_W-1:0]          input_2_o,
	output logic [`MCR_PORT_W-1:0]          input_3_o,
	output logic [`MCR_PORT_W-1:0]          input_4_o
);

	import mcr_input_pkg::*;

	game_e                           game;
	logic [`MCR_CTRL_W-1:0]          ctrl;
	logic signed [`MCR_WACKO_W-1:0]  wacko_x;
	logic signed [`MCR_WACKO_W-1:0]  wacko_y;
	logic signed [`MCR_KROOZR_W-1:0] kroozr_x;
	logic signed [`MCR_KROOZR_W-1:0] kroozr_y;
	logic [1:0]                      mouse_btn;
	logic [`MCR_ANGLE_W-1:0]         angle;
	logic                            spin_left;
	logic                            spin_right;

	// Stick directions double as spinner buttons
	assign spin_left  = p1_btn_i[`BTN_LEFT] | p1_btn_i[`BTN_UP];
	assign spin_right = p1_btn_i[`BTN_RIGHT] | p1_btn_i[`BTN_DOWN];

	mcr_cfg_regs mcr_cfg_regs_inst (
		.clk_sys   (clk_sys),
		.rst_n_i   (rst_n_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.game_o    (game),
		.ctrl_o    (ctrl)
	);

	mcr_mouse_track mcr_mouse_track_inst (
		.clk_sys        (clk_sys),
		.rst_n_i        (rst_n_i),
		.mouse_strobe_i (mouse_strobe_i),
		.mouse_x_i      (mouse_x_i),
		.mouse_y_i      (mouse_y_i),
		.mouse_btn_i    (mouse_btn_i),
		.rotate_i       (ctrl[`CTRL_ROTATE]),
		.wacko_x_o      (wacko_x),
		.wacko_y_o      (wacko_y),
		.kroozr_x_o     (kroozr_x),
		.kroozr_y_o     (kroozr_y),
		.mouse_btn_o    (mouse_btn)
	);

	mcr_spinner mcr_spinner_inst (
		.clk_sys      (clk_sys),
		.rst_n_i      (rst_n_i),
		.vblank_i     (vblank_i),
		.spin_left_i  (spin_left),
		.spin_right_i (spin_right),
		.fast_i       (ctrl[`CTRL_SPIN_FAST]),
		.angle_o      (angle)
	);

	mcr_port_map mcr_port_map_inst (
		.clk_sys     (clk_sys),
		.rst_n_i     (rst_n_i),
		.game_i      (game),
		.ctrl_i      (ctrl),
		.p1_btn_i    (p1_btn_i),
		.p2_btn_i    (p2_btn_i),
		.sys_btn_i   (sys_btn_i),
		.wacko_x_i   (wacko_x),
		.wacko_y_i   (wacko_y),
		.kroozr_x_i  (kroozr_x),
		.kroozr_y_i  (kroozr_y),
		.mouse_btn_i (mouse_btn),
		.angle_i     (angle),
		.input_0_o   (input_0_o),
		.input_1_o   (input_1_o),
		.input_2_o   (input_2_o),
		.input_3_o   (input_3_o),
		.input_4_o   (input_4_o)
	);

endmodule

//--- tb_mcr_input.sv
//======================================================================
// Self-checking testbench for the MCR-II input front end
// A reference model tracks mouse, spinner and config state and
// predicts all five port bytes. Stops at the first mismatch
//======================================================================
`include "mcr_input_defs.svh"

module tb_mcr_input;

	import mcr_input_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int DRV_DLY    = 2;     // Input drive delay after the edge
	localparam int MAX_CYCLES = 4000;  // All tests together run well under 1000 cycles
	localparam int KR_MAX     = (1 << (`MCR_KROOZR_W - 1)) - 1;
	localparam int KR_MIN     = -(1 << (`MCR_KROOZR_W - 1));

	logic                            clk_sys;
	logic                            rst_n_i;
	logic                            psel_i;
	logic                            penable_i;
	logic                            pwrite_i;
	logic [`MCR_APB_AW-1:0]          paddr_i;
	logic [31:0]                     pwdata_i;
	logic [31:0]                     prdata_o;
	logic                            pready_o;
	logic [`MCR_BTN_W-1:0]           p1_btn_i;
	logic [`MCR_BTN_W-1:0]           p2_btn_i;
	logic [`MCR_SYS_W-1:0]           sys_btn_i;
	logic                            mouse_strobe_i;
	logic signed [`MCR_MOUSE_W-1:0]  mouse_x_i;
	logic signed [`MCR_MOUSE_W-1:0]  mouse_y_i;
	logic [1:0]                      mouse_btn_i;
	logic                            vblank_i;
	logic [`MCR_PORT_W-1:0]          input_0_o;
	logic [`MCR_PORT_W-1:0]          input_1_o;
	logic [`MCR_PORT_W-1:0]          input_2_o;
	logic [`MCR_PORT_W-1:0]          input_3_o;
	logic [`MCR_PORT_W-1:0]          input_4_o;

	integer seed;
	int     cycle_cnt = 0;
	int     check_cnt = 0;
	logic   cmp_busy = 1'b0;
	string  cmp_name;

	// Reference model state
	game_e                           m_game;
	logic [`MCR_CTRL_W-1:0]          m_ctrl;
	logic [`MCR_WACKO_W-1:0]         m_wx;
	logic [`MCR_WACKO_W-1:0]         m_wy;
	logic signed [`MCR_KROOZR_W-1:0] m_kx;
	logic signed [`MCR_KROOZR_W-1:0] m_ky;
	logic [1:0]                      m_mbtn;
	logic [`MCR_ANGLE_W-1:0]         m_angle;

	mcr_input_top mcr_input_top_inst (
		.clk_sys        (clk_sys),
		.rst_n_i        (rst_n_i),
		.psel_i         (psel_i),
		.penable_i      (penable_i),
		.pwrite_i       (pwrite_i),
		.paddr_i        (paddr_i),
		.pwdata_i       (pwdata_i),
		.prdata_o       (prdata_o),
		.pready_o       (pready_o),
		.p1_btn_i       (p1_btn_i),
		.p2_btn_i       (p2_btn_i),
		.sys_btn_i      (sys_btn_i),
		.mouse_strobe_i (mouse_strobe_i),
		.mouse_x_i      (mouse_x_i),
		.mouse_y_i      (mouse_y_i),
		.mouse_btn_i    (mouse_btn_i),
		.vblank_i       (vblank_i),
		.input_0_o      (input_0_o),
		.input_1_o      (input_1_o),
		.input_2_o      (input_2_o),
		.input_3_o      (input_3_o),
		.input_4_o      (input_4_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
			$display("*** FAILED ***");
			$fatal(1, "simulation stopped on timeout");
		end
	end

	//==================================================================
	// Compare tasks
	//==================================================================
	task automatic check_port(input string name, input logic [`MCR_PORT_W-1:0] exp_v,
	                          input logic [`MCR_PORT_W-1:0] act_v);
		check_cnt++;
		if (act_v !== exp_v) begin
			$display("Fail %s: expected %02h, actual %02h", name, exp_v, act_v);
			$display("*** FAILED ***");
			$fatal(1, "port byte mismatch");
		end
	endtask

	task automatic check_reg(input string name, input logic [31:0] exp_v,
	                         input logic [31:0] act_v);
		check_cnt++;
		if (act_v !== exp_v) begin
			$display("Fail %s: expected %08h, actual %08h", name, exp_v, act_v);
			$display("*** FAILED ***");
			$fatal(1, "register read mismatch");
		end
	endtask

	// Zero wait states mean pready is high in every access phase
	task automatic require_ready(input string name);
		check_cnt++;
		if (pready_o !== 1'b1) begin
			$display("%s: the slave held pready_o low in the access phase", name);
			$display("*** FAILED ***");
			$fatal(1, "APB handshake missing");
		end
	endtask

	//==================================================================
	// Reference mapping
	//==================================================================
	function automatic logic [3:0] udlr_bits(input logic [`MCR_BTN_W-1:0] b);
		return {b[`BTN_UP], b[`BTN_DOWN], b[`BTN_LEFT], b[`BTN_RIGHT]};
	endfunction

	function automatic logic [3:0] drul_bits(input logic [`MCR_BTN_W-1:0] b);
		return {b[`BTN_DOWN], b[`BTN_UP], b[`BTN_RIGHT], b[`BTN_LEFT]};
	endfunction

	function automatic logic [3:0] fire_rl_bits(input logic [`MCR_BTN_W-1:0] b);
		return {b[`BTN_FIRE_A], b[`BTN_FIRE_B], b[`BTN_RIGHT], b[`BTN_LEFT]};
	endfunction

	function automatic logic known_game(input logic [2:0] code);
		return (code == GAME_SHOLLOW) || (code == GAME_WACKO) ||
		       (code == GAME_KROOZR) || (code == GAME_DOMINO);
	endfunction

	// Index 0 is input_0
	function automatic logic [4:0][`MCR_PORT_W-1:0] expected_ports();
		logic [4:0][`MCR_PORT_W-1:0] p;
		logic                        x;
		p = {5{`MCR_PORT_IDLE}};
		x = 1'b0;
		case (m_game)
			GAME_SHOLLOW: begin
				p[1] = ~{fire_rl_bits(p2_btn_i), fire_rl_bits(p1_btn_i)};
				p[3] = 8'hFD;
			end
			GAME_WACKO: begin
				p[1] = m_wx[`MCR_WACKO_W-1 -: `MCR_PORT_W];
				p[2] = m_wy[`MCR_WACKO_W-1 -: `MCR_PORT_W];
				p[3] = 8'hBF;
				p[4] = ~{udlr_bits(p2_btn_i), udlr_bits(p1_btn_i)};
			end
			GAME_KROOZR: begin
				x    = p1_btn_i[`BTN_FIRE_A] | m_mbtn[0];
				p[1] = ~{p1_btn_i[`BTN_FIRE_B] | m_mbtn[1], m_angle[6], 3'b111, m_angle[5:3]};
				p[2] = {{2{m_kx[`MCR_KROOZR_W-1]}}, m_kx[7:2]};
				p[3] = 8'hBF;
				p[4] = {{2{m_ky[`MCR_KROOZR_W-1]}}, m_ky[7:2]};
			end
			GAME_DOMINO: begin
				x    = p1_btn_i[`BTN_FIRE_A];
				p[1] = ~{4'b0000, drul_bits(p1_btn_i)};
				p[2] = ~{3'b000, p2_btn_i[`BTN_FIRE_A], drul_bits(p2_btn_i)};
				p[3] = ~{6'b010000, m_ctrl[`CTRL_SKIN], m_ctrl[`CTRL_MUSIC]};
			end
			default: ;
		endcase
		p[0] = ~{m_ctrl[`CTRL_SERVICE], 1'b0, sys_btn_i[`SYS_TILT], x,
		         sys_btn_i[`SYS_START2], sys_btn_i[`SYS_START1],
		         sys_btn_i[`SYS_COIN2], sys_btn_i[`SYS_COIN1]};
		return p;
	endfunction

	// Compare process that runs on request from the stimulus
	always begin
		logic [4:0][`MCR_PORT_W-1:0] exp_ports;
		logic [4:0][`MCR_PORT_W-1:0] act_ports;
		wait (cmp_busy);
		exp_ports = expected_ports();
		act_ports = {input_4_o, input_3_o, input_2_o, input_1_o, input_0_o};
		for (int i = 0; i < 5; i++) begin
			check_port($sformatf("%s input_%0d", cmp_name, i), exp_ports[i], act_ports[i]);
		end
		cmp_busy = 1'b0;
	end

	//==================================================================
	// Stimulus tasks
	//==================================================================
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#DRV_DLY;
	endtask

	task automatic compare_after(input string name, input int cycles);
		wait_cycles(cycles);
		cmp_name = name;
		cmp_busy = 1'b1;
		wait (!cmp_busy);
	endtask

	task automatic write_reg(input logic [`MCR_APB_AW-1:0] addr, input logic [31:0] data);
		psel_i    = 1'b1;
		penable_i = 1'b0;
		pwrite_i  = 1'b1;
		paddr_i   = addr;
		pwdata_i  = data;
		wait_cycles(1);
		penable_i = 1'b1;
		#(CLK_PERIOD / 4);  // Mid access phase
		require_ready("APB write");
		wait_cycles(1);  // Write commits here
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
		if (addr == REG_GAME && known_game(data[2:0])) begin
			m_game = game_e'(data[2:0]);
		end else if (addr == REG_CTRL) begin
			m_ctrl = data[`MCR_CTRL_W-1:0];
		end
	endtask

	task automatic read_reg(input logic [`MCR_APB_AW-1:0] addr, output logic [31:0] data);
		psel_i    = 1'b1;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
		paddr_i   = addr;
		wait_cycles(1);
		penable_i = 1'b1;
		#(CLK_PERIOD / 4);  // Mid access phase
		data = prdata_o;
		require_ready("APB read");
		wait_cycles(1);
		psel_i    = 1'b0;
		penable_i = 1'b0;
	endtask

	task automatic move_mouse(input string name, input int dx, input int dy,
	                          input logic [1:0] btn);
		int mx;
		int my;
		int nx;
		int ny;
		mouse_x_i      = dx[`MCR_MOUSE_W-1:0];
		mouse_y_i      = dy[`MCR_MOUSE_W-1:0];
		mouse_btn_i    = btn;
		mouse_strobe_i = 1'b1;
		m_mbtn = btn;
		// Wacko wraps at 11 bits
		nx = m_ctrl[`CTRL_ROTATE] ? int'(m_wx) - dy : int'(m_wx) + dx;
		ny = m_ctrl[`CTRL_ROTATE] ? int'(m_wy) + dx : int'(m_wy) + dy;
		m_wx = nx[`MCR_WACKO_W-1:0];
		m_wy = ny[`MCR_WACKO_W-1:0];
		// Krooz'r axis holds when the result leaves the 10-bit range
		mx = m_ctrl[`CTRL_ROTATE] ? -dy : dx;
		my = m_ctrl[`CTRL_ROTATE] ? dx : dy;
		nx = int'(m_kx) - mx;
		ny = int'(m_ky) + my;
		if (nx >= KR_MIN && nx <= KR_MAX) m_kx = nx[`MCR_KROOZR_W-1:0];
		if (ny >= KR_MIN && ny <= KR_MAX) m_ky = ny[`MCR_KROOZR_W-1:0];
		wait_cycles(1);
		mouse_strobe_i = 1'b0;
		compare_after(name, 1);
	endtask

	task automatic pulse_vblank(input string name);
		logic left;
		logic right;
		int   step;
		int   a;
		left  = p1_btn_i[`BTN_LEFT] | p1_btn_i[`BTN_UP];
		right = p1_btn_i[`BTN_RIGHT] | p1_btn_i[`BTN_DOWN];
		step  = m_ctrl[`CTRL_SPIN_FAST] ? 2 : 1;
		a     = int'(m_angle);
		if (left && !right) a = a - step;
		if (right && !left) a = a + step;
		m_angle  = a[`MCR_ANGLE_W-1:0];
		vblank_i = 1'b1;
		wait_cycles(1);
		vblank_i = 1'b0;
		compare_after(name, 2);  // Edge detect, angle, port byte
	endtask

	task automatic exercise_buttons(input game_e g, input string name);
		logic [31:0] rnd;
		write_reg(REG_GAME, {29'd0, g});
		for (int i = 0; i < 20; i++) begin
			rnd = $random(seed);
			if (i % 5 == 0) begin
				write_reg(REG_CTRL, {27'd0, rnd[31:27]});
			end
			p1_btn_i  = rnd[5:0];
			p2_btn_i  = rnd[11:6];
			sys_btn_i = rnd[16:12];
			compare_after(name, 1);
		end
	endtask

	//==================================================================
	// Test sequence
	//==================================================================
	initial begin
		logic [31:0] rnd;
		logic [31:0] rdata;
		int          dx;
		int          dy;
		seed           = 40;
		rst_n_i        = 1'b0;
		psel_i         = 1'b0;
		penable_i      = 1'b0;
		pwrite_i       = 1'b0;
		paddr_i        = '0;
		pwdata_i       = '0;
		p1_btn_i       = '0;
		p2_btn_i       = '0;
		sys_btn_i      = '0;
		mouse_strobe_i = 1'b0;
		mouse_x_i      = '0;
		mouse_y_i      = '0;
		mouse_btn_i    = 2'b00;
		vblank_i       = 1'b0;
		m_game  = GAME_SHOLLOW;
		m_ctrl  = '0;
		m_wx    = '0;
		m_wy    = '0;
		m_kx    = '0;
		m_ky    = '0;
		m_mbtn  = 2'b00;
		m_angle = '0;
		wait_cycles(2);
		rst_n_i = 1'b1;

		// Reset state
		check_port("reset input_0", `MCR_PORT_IDLE, input_0_o);
		check_port("reset input_1", `MCR_PORT_IDLE, input_1_o);
		check_port("reset input_2", `MCR_PORT_IDLE, input_2_o);
		check_port("reset input_3", `MCR_PORT_IDLE, input_3_o);
		check_port("reset input_4", `MCR_PORT_IDLE, input_4_o);
		check_reg("reset prdata", 32'd0, prdata_o);
		read_reg(REG_GAME, rdata);
		check_reg("reset GAME", 32'd0, rdata);
		read_reg(REG_CTRL, rdata);
		check_reg("reset CTRL", 32'd0, rdata);

		// Register access, illegal codes and unmapped offsets
		write_reg(REG_GAME, 32'd3);
		read_reg(REG_GAME, rdata);
		check_reg("GAME write", 32'd3, rdata);
		write_reg(REG_CTRL, 32'hFFFF_FFF5);
		read_reg(REG_CTRL, rdata);
		check_reg("CTRL write", 32'h15, rdata);
		write_reg(REG_GAME, 32'd7);
		write_reg(REG_GAME, 32'd2);
		read_reg(REG_GAME, rdata);
		check_reg("GAME illegal code", 32'd3, rdata);
		write_reg(4'h8, 32'hFFFF_FFFC);  // Low bits form a legal game code
		read_reg(4'h8, rdata);
		check_reg("unmapped read", 32'd0, rdata);
		read_reg(REG_CTRL, rdata);
		check_reg("CTRL after unmapped write", 32'h15, rdata);
		read_reg(REG_GAME, rdata);
		check_reg("GAME after unmapped write", 32'd3, rdata);
		write_reg(REG_CTRL, 32'd0);
		compare_after("register update", 1);

		exercise_buttons(GAME_SHOLLOW, "shollow");
		exercise_buttons(GAME_DOMINO, "domino");

		// Wacko with rotate off then on
		sys_btn_i = '0;
		write_reg(REG_GAME, {29'd0, GAME_WACKO});
		write_reg(REG_CTRL, 32'd0);
		for (int i = 0; i < 50; i++) begin
			if (i == 25) begin
				write_reg(REG_CTRL, 32'd1 << `CTRL_ROTATE);
			end
			rnd = $random(seed);
			p1_btn_i = rnd[5:0];
			p2_btn_i = rnd[11:6];
			dx = $random(seed) % 256;
			dy = $random(seed) % 256;
			move_mouse("wacko", dx, dy, rnd[13:12]);
		end

		// Krooz'r saturation and mouse buttons
		p1_btn_i = '0;
		p2_btn_i = '0;
		write_reg(REG_GAME, {29'd0, GAME_KROOZR});
		write_reg(REG_CTRL, 32'd0);
		for (int i = 0; i < 8; i++) move_mouse("kroozr x up", -250, 0, i[1:0]);
		for (int i = 0; i < 8; i++) move_mouse("kroozr y up", 0, 250, i[1:0]);
		for (int i = 0; i < 8; i++) move_mouse("kroozr x down", 250, 0, i[1:0]);
		for (int i = 0; i < 8; i++) move_mouse("kroozr y down", 0, -250, i[1:0]);
		write_reg(REG_CTRL, 32'd1 << `CTRL_ROTATE);
		for (int i = 0; i < 4; i++) move_mouse("kroozr rotated", -250, 0, i[1:0]);

		// Spinner at normal and fast speed
		write_reg(REG_CTRL, 32'd0);
		p1_btn_i = 6'd1 << `BTN_RIGHT;
		repeat (10) pulse_vblank("spin right");
		p1_btn_i = 6'd1 << `BTN_UP;
		repeat (20) pulse_vblank("spin left");
		write_reg(REG_CTRL, 32'd1 << `CTRL_SPIN_FAST);
		p1_btn_i = 6'd1 << `BTN_DOWN;
		repeat (30) pulse_vblank("spin right fast");
		p1_btn_i = 6'd1 << `BTN_LEFT;
		repeat (10) pulse_vblank("spin left fast");
		p1_btn_i = (6'd1 << `BTN_LEFT) | (6'd1 << `BTN_RIGHT);
		repeat (3) pulse_vblank("spin both held");

		if (check_cnt > 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("No checks were run");
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+.
mcr_input_pkg.sv
mcr_cfg_regs.sv
mcr_mouse_track.sv
mcr_spinner.sv
mcr_port_map.sv
mcr_input_top.sv
tb_mcr_input.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MCR-II input testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_mcr_input -o tb_mcr_input
./obj_dir/tb_mcr_input 2>&1 | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
	echo "Simulation ended without a result, see sim.log"
	exit 1
fi
echo "Simulation passed"
